/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --timing --assert --timescale 1ns/1ps
TOP       := tb_soc_io
RTL_TOP   := soc_io_top
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o sim_$(TOP)
	./$(BUILD_DIR)/sim_$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/soc_pkg.sv */
// ------------------------------------------------
// soc_pkg
// shared widths, bus types, I/O register offsets
// and interrupt bit positions of the I/O fabric
// ------------------------------------------------
package soc_pkg;

  // bus and pad widths
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int GPIO_W = 16;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [GPIO_W-1:0] gpio_t;
  typedef logic [31:0]       irq_vec_t;

  // trap destination and gpio interrupt source codes, 0 means off
  typedef logic [1:0] sel2_t;

  // upper 24 address bits of the register page
  localparam logic [23:0] IO_PAGE = 24'h0300_00;

  // gpio pad registers
  localparam logic [7:0] REG_GPIO      = 8'h00;
  localparam logic [7:0] REG_GPIO_OEB  = 8'h04;
  localparam logic [7:0] REG_GPIO_PU   = 8'h08;
  localparam logic [7:0] REG_GPIO_PD   = 8'h0C;

  // read-only identity
  localparam logic [7:0] REG_MFGR      = 8'h24;
  localparam logic [7:0] REG_PROD      = 8'h28;
  localparam logic [7:0] REG_MASK      = 8'h2C;
  localparam logic [7:0] REG_CLKSEL    = 8'h30;

  // routing selects
  localparam logic [7:0] REG_TRAP_DEST = 8'h3C;
  localparam logic [7:0] REG_IRQ7_SRC  = 8'h40;
  localparam logic [7:0] REG_IRQ8_SRC  = 8'h44;

  // counter timer
  localparam logic [7:0] REG_TIM_CFG   = 8'h5C;
  localparam logic [7:0] REG_TIM_VAL   = 8'h60;
  localparam logic [7:0] REG_TIM_DAT   = 8'h64;

  // interrupt vector bit positions, the rest stay low
  localparam int IRQ_PIN   = 5;
  localparam int IRQ_SPI   = 6;
  localparam int IRQ_GPIO7 = 7;
  localparam int IRQ_GPIO8 = 8;
  localparam int IRQ_TIM0  = 11;

endpackage

/* filelist.f */
common/soc_pkg.sv
hdl/mem_decode.sv
sysctl/sysctl_regs.sv
sysctl/pad_ctrl.sv
timer/counter_timer.sv
hdl/soc_io_top.sv
verif/tb_soc_io.sv

/* hdl/mem_decode.sv */
// ------------------------------------------------
// mem_decode
// splits native core requests into SRAM, I/O page
// and unmapped space, registers ready and I/O data
// ------------------------------------------------
module mem_decode #(
  parameter int MEM_WORDS = 32768
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         mem_valid_i,
  input  soc_pkg::word_t               mem_addr_i,
  input  soc_pkg::word_t               mem_wdata_i,
  input  soc_pkg::strb_t               mem_wstrb_i,
  input  soc_pkg::word_t               ram_rdata_i,
  input  soc_pkg::word_t               sys_rdata_i,
  input  soc_pkg::word_t               tim_rdata_i,
  output logic                         mem_ready_o,
  output soc_pkg::word_t               mem_rdata_o,
  output soc_pkg::strb_t               ram_wstrb_o,
  output logic [$clog2(MEM_WORDS)-1:0] ram_addr_o,
  output soc_pkg::word_t               ram_wdata_o,
  output soc_pkg::strb_t               io_we_o,
  output logic                         io_re_o,
  output logic [7:0]                   io_off_o,
  output soc_pkg::word_t               io_wdata_o
);

  localparam int RAM_AW = $clog2(MEM_WORDS);
  localparam soc_pkg::word_t RAM_TOP = soc_pkg::word_t'(4 * MEM_WORDS);

  logic           pending;
  logic           is_ram;
  logic           is_io;
  logic           ready_q;
  logic           ram_sel_q;
  soc_pkg::word_t io_rdata_q;

  // request seen but not yet answered
  assign pending = mem_valid_i && !ready_q;

  assign is_ram = mem_addr_i < RAM_TOP;
  assign is_io  = mem_addr_i[31:8] == soc_pkg::IO_PAGE;

  // sram port, strobes live only in the grant cycle
  assign ram_wstrb_o = (pending && is_ram) ? mem_wstrb_i : '0;
  assign ram_addr_o  = mem_addr_i[RAM_AW+1:2];
  assign ram_wdata_o = mem_wdata_i;

  // register page grant
  assign io_we_o    = (pending && is_io) ? mem_wstrb_i : '0;
  assign io_re_o    = pending && is_io && (mem_wstrb_i == '0);
  assign io_off_o   = mem_addr_i[7:0];
  assign io_wdata_o = mem_wdata_i;

  // every target answers one cycle after valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q   <= 1'b0;
      ram_sel_q <= 1'b0;
    end else begin
      ready_q <= pending;
      if (pending) begin
        ram_sel_q <= is_ram;
      end
    end
  end

  // unowned offsets come back as zero from both blocks,
  // and unmapped space reads zero as well
  always_ff @(posedge clk_i) begin
    if (pending && !is_ram) begin
      io_rdata_q <= is_io ? (sys_rdata_i | tim_rdata_i) : '0;
    end
  end

  assign mem_ready_o = ready_q;
  assign mem_rdata_o = ram_sel_q ? ram_rdata_i : io_rdata_q;

  // the core holds valid until ready, so ready never stands alone
  ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_ready_o |-> mem_valid_i
  );

endmodule

/* hdl/soc_io_top.sv */
// ------------------------------------------------
// soc_io_top
// memory-mapped I/O fabric around the core port,
// builds the 32-bit interrupt vector
// ------------------------------------------------
module soc_io_top #(
  parameter int MEM_WORDS = 32768
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         mem_valid_i,
  input  soc_pkg::word_t               mem_addr_i,
  input  soc_pkg::word_t               mem_wdata_i,
  input  soc_pkg::strb_t               mem_wstrb_i,
  input  soc_pkg::word_t               ram_rdata_i,
  input  logic                         trap_i,
  input  logic                         irq_pin_i,
  input  logic                         irq_spi_i,
  input  soc_pkg::gpio_t               gpio_in_i,
  input  logic [11:0]                  mfgr_id_i,
  input  logic [7:0]                   prod_id_i,
  input  logic [3:0]                   mask_rev_i,
  input  logic                         clk_ext_sel_i,
  output logic                         mem_ready_o,
  output soc_pkg::word_t               mem_rdata_o,
  output soc_pkg::strb_t               ram_wstrb_o,
  output logic [$clog2(MEM_WORDS)-1:0] ram_addr_o,
  output soc_pkg::word_t               ram_wdata_o,
  output soc_pkg::irq_vec_t            irq_o,
  output soc_pkg::gpio_t               gpio_out_o,
  output soc_pkg::gpio_t               gpio_outenb_o,
  output soc_pkg::gpio_t               gpio_pullupb_o,
  output soc_pkg::gpio_t               gpio_pulldownb_o
);

  // register page bus
  soc_pkg::strb_t io_we;
  logic           io_re;
  logic [7:0]     io_off;
  soc_pkg::word_t io_wdata;
  soc_pkg::word_t sys_rdata;
  soc_pkg::word_t tim_rdata;

  // register values towards the pads
  soc_pkg::gpio_t gpio_reg;
  soc_pkg::gpio_t gpio_oeb;
  soc_pkg::gpio_t gpio_pu;
  soc_pkg::gpio_t gpio_pd;
  soc_pkg::sel2_t trap_dest;
  soc_pkg::sel2_t irq7_src;
  soc_pkg::sel2_t irq8_src;

  logic irq7;
  logic irq8;
  logic tim_irq;

  mem_decode #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_valid_i(mem_valid_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .ram_rdata_i(ram_rdata_i),
    .sys_rdata_i(sys_rdata),
    .tim_rdata_i(tim_rdata),
    .mem_ready_o(mem_ready_o),
    .mem_rdata_o(mem_rdata_o),
    .ram_wstrb_o(ram_wstrb_o),
    .ram_addr_o (ram_addr_o),
    .ram_wdata_o(ram_wdata_o),
    .io_we_o    (io_we),
    .io_re_o    (io_re),
    .io_off_o   (io_off),
    .io_wdata_o (io_wdata)
  );

  sysctl_regs u_sysctl_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .io_we_i      (io_we),
    .io_off_i     (io_off),
    .io_wdata_i   (io_wdata),
    .gpio_in_i    (gpio_in_i),
    .gpio_out_i   (gpio_out_o),
    .mfgr_id_i    (mfgr_id_i),
    .prod_id_i    (prod_id_i),
    .mask_rev_i   (mask_rev_i),
    .clk_ext_sel_i(clk_ext_sel_i),
    .rdata_o      (sys_rdata),
    .gpio_o       (gpio_reg),
    .gpio_oeb_o   (gpio_oeb),
    .gpio_pu_o    (gpio_pu),
    .gpio_pd_o    (gpio_pd),
    .trap_dest_o  (trap_dest),
    .irq7_src_o   (irq7_src),
    .irq8_src_o   (irq8_src)
  );

  pad_ctrl u_pad_ctrl (
    .rst_n_i         (rst_n_i),
    .gpio_i          (gpio_reg),
    .gpio_oeb_i      (gpio_oeb),
    .gpio_pu_i       (gpio_pu),
    .gpio_pd_i       (gpio_pd),
    .trap_dest_i     (trap_dest),
    .irq7_src_i      (irq7_src),
    .irq8_src_i      (irq8_src),
    .trap_i          (trap_i),
    .gpio_in_i       (gpio_in_i),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o),
    .irq7_o          (irq7),
    .irq8_o          (irq8)
  );

  counter_timer u_counter_timer (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .io_we_i   (io_we),
    .io_re_i   (io_re),
    .io_off_i  (io_off),
    .io_wdata_i(io_wdata),
    .rdata_o   (tim_rdata),
    .irq_o     (tim_irq)
  );

  // unused vector bits stay low
  always_comb begin
    irq_o                     = '0;
    irq_o[soc_pkg::IRQ_PIN]   = irq_pin_i;
    irq_o[soc_pkg::IRQ_SPI]   = irq_spi_i;
    irq_o[soc_pkg::IRQ_GPIO7] = irq7;
    irq_o[soc_pkg::IRQ_GPIO8] = irq8;
    irq_o[soc_pkg::IRQ_TIM0]  = tim_irq;
  end

endmodule

/* sysctl/pad_ctrl.sv */
// ------------------------------------------------
// pad_ctrl
// trap override on pads 11 to 13, output enable
// hold in reset and gpio interrupt source muxes
// ------------------------------------------------
module pad_ctrl (
  input  logic           rst_n_i,
  input  soc_pkg::gpio_t gpio_i,
  input  soc_pkg::gpio_t gpio_oeb_i,
  input  soc_pkg::gpio_t gpio_pu_i,
  input  soc_pkg::gpio_t gpio_pd_i,
  input  soc_pkg::sel2_t trap_dest_i,
  input  soc_pkg::sel2_t irq7_src_i,
  input  soc_pkg::sel2_t irq8_src_i,
  input  logic           trap_i,
  input  soc_pkg::gpio_t gpio_in_i,
  output soc_pkg::gpio_t gpio_out_o,
  output soc_pkg::gpio_t gpio_outenb_o,
  output soc_pkg::gpio_t gpio_pullupb_o,
  output soc_pkg::gpio_t gpio_pulldownb_o,
  output logic           irq7_o,
  output logic           irq8_o
);

  // pick one of three inputs, code 0 keeps the line low
  function automatic logic src_pick(soc_pkg::sel2_t src, logic [2:0] bits);
    return (src == 2'd0) ? 1'b0 : bits[src-2'd1];
  endfunction

  logic           route_on;
  soc_pkg::gpio_t trap_pads;

  assign route_on  = trap_dest_i != 2'd0;
  // pads 11, 12 and 13 are the trap group
  assign trap_pads = route_on ? soc_pkg::gpio_t'(16'h3800) : '0;

  always_comb begin
    gpio_out_o = gpio_i;
    if (route_on) begin
      gpio_out_o[10 + int'(trap_dest_i)] = trap_i;
    end
  end

  // pads stay undriven while reset is asserted
  assign gpio_outenb_o    = {16{~rst_n_i}} | (gpio_oeb_i & ~trap_pads);
  assign gpio_pullupb_o   = gpio_pu_i | trap_pads;
  assign gpio_pulldownb_o = gpio_pd_i | trap_pads;

  assign irq7_o = src_pick(irq7_src_i, gpio_in_i[2:0]);
  assign irq8_o = src_pick(irq8_src_i, gpio_in_i[5:3]);

endmodule

/* sysctl/sysctl_regs.sv */
// ------------------------------------------------
// sysctl_regs
// gpio pad registers, trap and irq routing selects
// and the read-only identity page
// ------------------------------------------------
module sysctl_regs (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  soc_pkg::strb_t io_we_i,
  input  logic [7:0]     io_off_i,
  input  soc_pkg::word_t io_wdata_i,
  input  soc_pkg::gpio_t gpio_in_i,
  input  soc_pkg::gpio_t gpio_out_i,
  input  logic [11:0]    mfgr_id_i,
  input  logic [7:0]     prod_id_i,
  input  logic [3:0]     mask_rev_i,
  input  logic           clk_ext_sel_i,
  output soc_pkg::word_t rdata_o,
  output soc_pkg::gpio_t gpio_o,
  output soc_pkg::gpio_t gpio_oeb_o,
  output soc_pkg::gpio_t gpio_pu_o,
  output soc_pkg::gpio_t gpio_pd_o,
  output soc_pkg::sel2_t trap_dest_o,
  output soc_pkg::sel2_t irq7_src_o,
  output soc_pkg::sel2_t irq8_src_o
);

  // byte lanes 0 and 1 of a pad register
  function automatic soc_pkg::gpio_t lane_wr(
    soc_pkg::gpio_t cur,
    soc_pkg::strb_t we,
    soc_pkg::word_t din
  );
    soc_pkg::gpio_t res;
    res = cur;
    if (we[0]) begin
      res[7:0] = din[7:0];
    end
    if (we[1]) begin
      res[15:8] = din[15:8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o      <= '0;
      gpio_oeb_o  <= '1;
      gpio_pu_o   <= '0;
      gpio_pd_o   <= '0;
      trap_dest_o <= '0;
      irq7_src_o  <= '0;
      irq8_src_o  <= '0;
    end else if (io_we_i != '0) begin
      case (io_off_i)
        soc_pkg::REG_GPIO:     gpio_o     <= lane_wr(gpio_o, io_we_i, io_wdata_i);
        soc_pkg::REG_GPIO_OEB: gpio_oeb_o <= lane_wr(gpio_oeb_o, io_we_i, io_wdata_i);
        soc_pkg::REG_GPIO_PU:  gpio_pu_o  <= lane_wr(gpio_pu_o, io_we_i, io_wdata_i);
        soc_pkg::REG_GPIO_PD:  gpio_pd_o  <= lane_wr(gpio_pd_o, io_we_i, io_wdata_i);
        // selects sit in byte 0
        soc_pkg::REG_TRAP_DEST: begin
          if (io_we_i[0]) begin
            trap_dest_o <= io_wdata_i[1:0];
          end
        end
        soc_pkg::REG_IRQ7_SRC: begin
          if (io_we_i[0]) begin
            irq7_src_o <= io_wdata_i[1:0];
          end
        end
        soc_pkg::REG_IRQ8_SRC: begin
          if (io_we_i[0]) begin
            irq8_src_o <= io_wdata_i[1:0];
          end
        end
        default: ;
      endcase
    end
  end

  // read mux, offsets owned elsewhere return zero
  always_comb begin
    rdata_o = '0;
    case (io_off_i)
      soc_pkg::REG_GPIO:      rdata_o = {gpio_out_i, gpio_in_i};
      soc_pkg::REG_GPIO_OEB:  rdata_o = {16'd0, gpio_oeb_o};
      soc_pkg::REG_GPIO_PU:   rdata_o = {16'd0, gpio_pu_o};
      soc_pkg::REG_GPIO_PD:   rdata_o = {16'd0, gpio_pd_o};
      soc_pkg::REG_MFGR:      rdata_o = {20'd0, mfgr_id_i};
      soc_pkg::REG_PROD:      rdata_o = {24'd0, prod_id_i};
      soc_pkg::REG_MASK:      rdata_o = {28'd0, mask_rev_i};
      soc_pkg::REG_CLKSEL:    rdata_o = {31'd0, clk_ext_sel_i};
      soc_pkg::REG_TRAP_DEST: rdata_o = {30'd0, trap_dest_o};
      soc_pkg::REG_IRQ7_SRC:  rdata_o = {30'd0, irq7_src_o};
      soc_pkg::REG_IRQ8_SRC:  rdata_o = {30'd0, irq8_src_o};
      default:                rdata_o = '0;
    endcase
  end

endmodule

/* timer/counter_timer.sv */
// ------------------------------------------------
// counter_timer
// down-counter with reload, one-shot or continuous
// mode and a single-cycle interrupt pulse
// ------------------------------------------------
module counter_timer (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  soc_pkg::strb_t io_we_i,
  input  logic           io_re_i,
  input  logic [7:0]     io_off_i,
  input  soc_pkg::word_t io_wdata_i,
  output soc_pkg::word_t rdata_o,
  output logic           irq_o
);

  function automatic soc_pkg::word_t byte_wr(
    soc_pkg::word_t cur,
    soc_pkg::strb_t we,
    soc_pkg::word_t din
  );
    soc_pkg::word_t res;
    res = cur;
    for (int b = 0; b < soc_pkg::STRB_W; b++) begin
      if (we[b]) begin
        res[8*b +: 8] = din[8*b +: 8];
      end
    end
    return res;
  endfunction

  // cfg bits {irq enable, continuous, enable}
  logic [2:0]     cfg_q;
  soc_pkg::word_t val_q;
  soc_pkg::word_t dat_q;
  logic           irq_q;
  logic           cfg_sel;
  logic           val_sel;
  logic           dat_sel;
  logic           bus_wr;

  assign cfg_sel = io_off_i == soc_pkg::REG_TIM_CFG;
  assign val_sel = io_off_i == soc_pkg::REG_TIM_VAL;
  assign dat_sel = io_off_i == soc_pkg::REG_TIM_DAT;
  // any write here holds the count for that cycle
  assign bus_wr  = (io_we_i != '0) && (cfg_sel || val_sel || dat_sel);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
      val_q <= '0;
      dat_q <= '0;
      irq_q <= 1'b0;
    end else begin
      irq_q <= 1'b0;
      if (cfg_sel && io_we_i[0]) begin
        cfg_q <= io_wdata_i[2:0];
      end
      if (val_sel) begin
        val_q <= byte_wr(val_q, io_we_i, io_wdata_i);
      end
      if (dat_sel) begin
        dat_q <= byte_wr(dat_q, io_we_i, io_wdata_i);
      end
      if (!bus_wr && cfg_q[0]) begin
        if (dat_q != '0) begin
          dat_q <= dat_q - 1'b1;
        end else begin
          irq_q <= cfg_q[2];
          if (cfg_q[1]) begin
            dat_q <= val_q;
          end else begin
            cfg_q[0] <= 1'b0;
          end
        end
      end
    end
  end

  assign irq_o = irq_q;

  // drive read data only during a read grant
  always_comb begin
    rdata_o = '0;
    if (io_re_i) begin
      case (io_off_i)
        soc_pkg::REG_TIM_CFG: rdata_o = {29'd0, cfg_q};
        soc_pkg::REG_TIM_VAL: rdata_o = val_q;
        soc_pkg::REG_TIM_DAT: rdata_o = dat_q;
        default:              rdata_o = '0;
      endcase
    end
  end

  // the pulse comes a cycle after the zero check, ie must still hold
  irq_needs_ie: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    irq_o |-> cfg_q[2]
  );

endmodule

/* verif/tb_soc_io.sv */
// ------------------------------------------------
// tb_soc_io
// random bus traffic against SRAM and register
// models, with pad, interrupt and timer checks
// ------------------------------------------------
module tb_soc_io;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WORDS = 1024;
  localparam int RAM_AW = $clog2(MEM_WORDS);
  localparam int N_SRAM = 200;
  localparam int N_GPIO = 40;
  // bus accesses over all phases including timer polls
  localparam int N_ACCESS = 2 * N_SRAM + 2 * N_GPIO + 160;
  localparam int CYCLE_LIMIT = 200 * N_ACCESS + 2000;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 mem_valid_i;
  soc_pkg::word_t       mem_addr_i;
  soc_pkg::word_t       mem_wdata_i;
  soc_pkg::strb_t       mem_wstrb_i;
  soc_pkg::word_t       ram_rdata_i = '0;
  logic                 trap_i;
  logic                 irq_pin_i;
  logic                 irq_spi_i;
  soc_pkg::gpio_t       gpio_in_i;
  logic [11:0]          mfgr_id_i;
  logic [7:0]           prod_id_i;
  logic [3:0]           mask_rev_i;
  logic                 clk_ext_sel_i;
  logic                 mem_ready_o;
  soc_pkg::word_t       mem_rdata_o;
  soc_pkg::strb_t       ram_wstrb_o;
  logic [RAM_AW-1:0]    ram_addr_o;
  soc_pkg::word_t       ram_wdata_o;
  soc_pkg::irq_vec_t    irq_o;
  soc_pkg::gpio_t       gpio_out_o;
  soc_pkg::gpio_t       gpio_outenb_o;
  soc_pkg::gpio_t       gpio_pullupb_o;
  soc_pkg::gpio_t       gpio_pulldownb_o;

  logic [31:0]    rng_state = 32'h5fc2_a7ce;
  int             val_errs = 0;
  int             other_errs = 0;
  int             tim_pulses = 0;
  soc_pkg::word_t sram [MEM_WORDS];
  soc_pkg::word_t ref_mem [MEM_WORDS];

  // register model
  soc_pkg::gpio_t m_gpio;
  soc_pkg::gpio_t m_oeb;
  soc_pkg::gpio_t m_pu;
  soc_pkg::gpio_t m_pd;
  soc_pkg::sel2_t m_trap;
  soc_pkg::sel2_t m_src7;
  soc_pkg::sel2_t m_src8;

  soc_io_top #(
    .MEM_WORDS(MEM_WORDS)
  ) soc_io_top_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_valid_i     (mem_valid_i),
    .mem_addr_i      (mem_addr_i),
    .mem_wdata_i     (mem_wdata_i),
    .mem_wstrb_i     (mem_wstrb_i),
    .ram_rdata_i     (ram_rdata_i),
    .trap_i          (trap_i),
    .irq_pin_i       (irq_pin_i),
    .irq_spi_i       (irq_spi_i),
    .gpio_in_i       (gpio_in_i),
    .mfgr_id_i       (mfgr_id_i),
    .prod_id_i       (prod_id_i),
    .mask_rev_i      (mask_rev_i),
    .clk_ext_sel_i   (clk_ext_sel_i),
    .mem_ready_o     (mem_ready_o),
    .mem_rdata_o     (mem_rdata_o),
    .ram_wstrb_o     (ram_wstrb_o),
    .ram_addr_o      (ram_addr_o),
    .ram_wdata_o     (ram_wdata_o),
    .irq_o           (irq_o),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // power-up content unique per word address
  function automatic soc_pkg::word_t fill_word(int unsigned idx);
    return {idx[15:0] ^ 16'h5a3c, ~idx[15:0]};
  endfunction

  function automatic soc_pkg::word_t io_addr(logic [7:0] off);
    return {soc_pkg::IO_PAGE, off};
  endfunction

  function automatic soc_pkg::gpio_t merge_lanes(
    soc_pkg::gpio_t cur,
    soc_pkg::strb_t strb,
    soc_pkg::word_t data
  );
    soc_pkg::gpio_t res;
    res = cur;
    if (strb[0]) begin
      res[7:0] = data[7:0];
    end
    if (strb[1]) begin
      res[15:8] = data[15:8];
    end
    return res;
  endfunction

  // pads 11 to 13 while a trap route is active
  function automatic soc_pkg::gpio_t trap_group();
    return (m_trap != 2'd0) ? 16'h3800 : 16'h0000;
  endfunction

  function automatic soc_pkg::irq_vec_t exp_irq();
    soc_pkg::irq_vec_t v;
    v = '0;
    v[soc_pkg::IRQ_PIN] = irq_pin_i;
    v[soc_pkg::IRQ_SPI] = irq_spi_i;
    if (m_src7 != 2'd0) begin
      v[soc_pkg::IRQ_GPIO7] = gpio_in_i[m_src7 - 1];
    end
    if (m_src8 != 2'd0) begin
      v[soc_pkg::IRQ_GPIO8] = gpio_in_i[m_src8 + 2];
    end
    return v;
  endfunction

  // SRAM with registered read and a fill while reset is low
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        sram[i] <= fill_word(i);
      end
    end else begin
      for (int b = 0; b < soc_pkg::STRB_W; b++) begin
        if (ram_wstrb_o[b]) begin
          sram[ram_addr_o][8*b +: 8] <= ram_wdata_o[8*b +: 8];
        end
      end
    end
    ram_rdata_i <= sram[ram_addr_o];
  end

  // one negedge sample per single-cycle timer pulse
  always @(negedge clk_i) begin
    if (irq_o[soc_pkg::IRQ_TIM0] === 1'b1) begin
      tim_pulses++;
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check_word(input string name, input soc_pkg::word_t exp,
                            input soc_pkg::word_t act);
    if (act !== exp) begin
      val_errs++;
      $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_gpio(input string name, input soc_pkg::gpio_t exp,
                            input soc_pkg::gpio_t act);
    if (act !== exp) begin
      val_errs++;
      $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input soc_pkg::irq_vec_t exp,
                           input soc_pkg::irq_vec_t act);
    if (act !== exp) begin
      val_errs++;
      $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // one request held until ready, which must rise one clock edge after valid
  task automatic bus_access(input soc_pkg::word_t addr, input soc_pkg::word_t wdata,
                            input soc_pkg::strb_t wstrb, output soc_pkg::word_t rdata);
    int waited;
    bit got;
    waited = 0;
    got = 1'b0;
    rdata = '0;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i  <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= wstrb;
    // the first negedge still lies in the valid cycle
    while (!got && waited < 9) begin
      @(negedge clk_i);
      waited++;
      got = mem_ready_o;
    end
    if (!got) begin
      other_errs++;
      $display("no ready within 8 cycles for address %h at %0t", addr, $time);
    end else begin
      rdata = mem_rdata_o;
      // strobes belong to the grant cycle only
      check_word("ram_wstrb_o", '0, soc_pkg::word_t'(ram_wstrb_o));
      if (waited != 2) begin
        other_errs++;
        $display("ready came %0d cycles after valid for address %h", waited - 1, addr);
      end
    end
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= '0;
  endtask

  task automatic write_reg(input soc_pkg::word_t addr, input soc_pkg::word_t data,
                           input soc_pkg::strb_t strb);
    soc_pkg::word_t discard;
    bus_access(addr, data, strb, discard);
  endtask

  task automatic read_reg(input soc_pkg::word_t addr, output soc_pkg::word_t data);
    bus_access(addr, '0, '0, data);
  endtask

  task automatic drive_pins(input soc_pkg::gpio_t gin, input logic trap,
                            input logic pin, input logic spi);
    @(posedge clk_i);
    gpio_in_i <= gin;
    trap_i    <= trap;
    irq_pin_i <= pin;
    irq_spi_i <= spi;
  endtask

  task automatic check_pads();
    soc_pkg::gpio_t exp_out;
    @(negedge clk_i);
    exp_out = m_gpio;
    if (m_trap != 2'd0) begin
      exp_out[10 + m_trap] = trap_i;
    end
    check_gpio("gpio_out_o", exp_out, gpio_out_o);
    check_gpio("gpio_outenb_o", m_oeb & ~trap_group(), gpio_outenb_o);
    check_gpio("gpio_pullupb_o", m_pu | trap_group(), gpio_pullupb_o);
    check_gpio("gpio_pulldownb_o", m_pd | trap_group(), gpio_pulldownb_o);
  endtask

  initial begin
    logic [31:0]    r;
    soc_pkg::word_t rd;
    soc_pkg::word_t wdata;
    soc_pkg::word_t exp;
    soc_pkg::strb_t strb;
    logic [7:0]     off;
    int             idx;
    int             base;
    int             polls;

    r = xorshift32();
    rst_n_i       = 1'b0;
    mem_valid_i   = 1'b0;
    mem_addr_i    = '0;
    mem_wdata_i   = '0;
    mem_wstrb_i   = '0;
    trap_i        = 1'b0;
    irq_pin_i     = 1'b0;
    irq_spi_i     = 1'b0;
    gpio_in_i     = '0;
    mfgr_id_i     = r[11:0];
    prod_id_i     = r[19:12];
    mask_rev_i    = r[23:20];
    clk_ext_sel_i = r[24];
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
    end
    m_gpio = '0;
    m_oeb  = '1;
    m_pu   = '0;
    m_pd   = '0;
    m_trap = '0;
    m_src7 = '0;
    m_src8 = '0;

    // reset state during and after reset
    @(posedge clk_i);
    @(negedge clk_i);
    check_gpio("gpio_outenb_o", '1, gpio_outenb_o);
    check_irq("irq_o", '0, irq_o);
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_word("mem_ready_o", '0, soc_pkg::word_t'(mem_ready_o));
    check_word("ram_wstrb_o", '0, soc_pkg::word_t'(ram_wstrb_o));
    check_irq("irq_o", '0, irq_o);
    check_pads();

    // SRAM traffic where reads often hit the word just written
    for (int n = 0; n < N_SRAM; n++) begin
      r = xorshift32();
      idx = r % MEM_WORDS;
      strb = (r[31:28] == 4'h0) ? 4'hf : r[31:28];
      wdata = xorshift32();
      write_reg(soc_pkg::word_t'(idx * 4), wdata, strb);
      for (int b = 0; b < soc_pkg::STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      if (!r[20]) begin
        idx = xorshift32() % MEM_WORDS;
      end
      read_reg(soc_pkg::word_t'(idx * 4), rd);
      check_word("mem_rdata_o", ref_mem[idx], rd);
    end

    // GPIO registers with byte lanes
    for (int n = 0; n < N_GPIO; n++) begin
      r = xorshift32();
      off = {4'h0, r[1:0], 2'b00};
      strb = (r[7:4] == 4'h0) ? 4'h3 : r[7:4];
      wdata = xorshift32();
      drive_pins(r[31:16], 1'b0, 1'b0, 1'b0);
      write_reg(io_addr(off), wdata, strb);
      case (off)
        soc_pkg::REG_GPIO:     m_gpio = merge_lanes(m_gpio, strb, wdata);
        soc_pkg::REG_GPIO_OEB: m_oeb  = merge_lanes(m_oeb, strb, wdata);
        soc_pkg::REG_GPIO_PU:  m_pu   = merge_lanes(m_pu, strb, wdata);
        default:               m_pd   = merge_lanes(m_pd, strb, wdata);
      endcase
      read_reg(io_addr(off), rd);
      case (off)
        soc_pkg::REG_GPIO:     exp = {m_gpio, gpio_in_i};
        soc_pkg::REG_GPIO_OEB: exp = {16'h0, m_oeb};
        soc_pkg::REG_GPIO_PU:  exp = {16'h0, m_pu};
        default:               exp = {16'h0, m_pd};
      endcase
      check_word("mem_rdata_o", exp, rd);
      check_pads();
    end

    // trap routing and gpio interrupt selects for every code
    for (int code = 0; code < 4; code++) begin
      m_trap = soc_pkg::sel2_t'(code);
      m_src7 = soc_pkg::sel2_t'(code);
      m_src8 = soc_pkg::sel2_t'(3 - code);
      write_reg(io_addr(soc_pkg::REG_TRAP_DEST), {30'h0, m_trap}, 4'h1);
      write_reg(io_addr(soc_pkg::REG_IRQ7_SRC), {30'h0, m_src7}, 4'h1);
      write_reg(io_addr(soc_pkg::REG_IRQ8_SRC), {30'h0, m_src8}, 4'h1);
      read_reg(io_addr(soc_pkg::REG_TRAP_DEST), rd);
      check_word("mem_rdata_o", {30'h0, m_trap}, rd);
      for (int k = 0; k < 6; k++) begin
        r = xorshift32();
        drive_pins(r[31:16], k[0], r[0], r[1]);
        check_pads();
        check_irq("irq_o", exp_irq(), irq_o);
      end
    end

    // identity page then unmapped space and unowned offsets
    read_reg(io_addr(soc_pkg::REG_MFGR), rd);
    check_word("mem_rdata_o", {20'h0, mfgr_id_i}, rd);
    read_reg(io_addr(soc_pkg::REG_PROD), rd);
    check_word("mem_rdata_o", {24'h0, prod_id_i}, rd);
    read_reg(io_addr(soc_pkg::REG_MASK), rd);
    check_word("mem_rdata_o", {28'h0, mask_rev_i}, rd);
    read_reg(io_addr(soc_pkg::REG_CLKSEL), rd);
    check_word("mem_rdata_o", {31'h0, clk_ext_sel_i}, rd);
    for (int n = 0; n < 4; n++) begin
      r = xorshift32();
      write_reg(32'h1000_0000 | (r & 32'h0fff_fffc), xorshift32(), 4'hf);
      read_reg(32'h1000_0000 | (r & 32'h0fff_fffc), rd);
      check_word("mem_rdata_o", '0, rd);
      read_reg(32'h0300_0100 | (r & 32'h0000_fefc), rd);
      check_word("mem_rdata_o", '0, rd);
    end
    read_reg(io_addr(8'h10), rd);
    check_word("mem_rdata_o", '0, rd);

    // one-shot timer with interrupt enable
    base = tim_pulses;
    write_reg(io_addr(soc_pkg::REG_TIM_DAT), 32'd20, 4'hf);
    write_reg(io_addr(soc_pkg::REG_TIM_CFG), 32'h5, 4'h1);
    polls = 0;
    rd = 32'h1;
    while (rd[0] && polls < 40) begin
      read_reg(io_addr(soc_pkg::REG_TIM_CFG), rd);
      polls++;
    end
    if (rd[0]) begin
      other_errs++;
      $display("one-shot timer still enabled after %0d polls", polls);
    end
    read_reg(io_addr(soc_pkg::REG_TIM_DAT), rd);
    check_word("tim_dat", '0, rd);
    check_word("tim0 pulse count", 32'd1, soc_pkg::word_t'(tim_pulses - base));

    // continuous mode keeps dat within the reload value
    base = tim_pulses;
    write_reg(io_addr(soc_pkg::REG_TIM_VAL), 32'd6, 4'hf);
    write_reg(io_addr(soc_pkg::REG_TIM_DAT), 32'd6, 4'hf);
    write_reg(io_addr(soc_pkg::REG_TIM_CFG), 32'h7, 4'h1);
    for (int n = 0; n < 30; n++) begin
      read_reg(io_addr(soc_pkg::REG_TIM_DAT), rd);
      if (rd > 32'd6) begin
        other_errs++;
        $display("timer count %0d above its reload value 6 at %0t", rd, $time);
      end
    end
    write_reg(io_addr(soc_pkg::REG_TIM_CFG), 32'h0, 4'h1);
    if (tim_pulses - base < 2) begin
      other_errs++;
      $display("continuous timer gave only %0d interrupt pulses", tim_pulses - base);
    end

    // with interrupt enable clear the counter wraps silently
    base = tim_pulses;
    write_reg(io_addr(soc_pkg::REG_TIM_DAT), 32'd5, 4'hf);
    write_reg(io_addr(soc_pkg::REG_TIM_CFG), 32'h3, 4'h1);
    for (int n = 0; n < 10; n++) begin
      read_reg(io_addr(soc_pkg::REG_TIM_DAT), rd);
    end
    write_reg(io_addr(soc_pkg::REG_TIM_CFG), 32'h0, 4'h1);
    check_word("tim0 pulse count", '0, soc_pkg::word_t'(tim_pulses - base));

    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
